// ==== design/recovery_pkg.sv ====
// Shared command, register selector and status types for the recovery executor and its tests
`default_nettype none

package recovery_pkg;

  // Register map word width
  localparam int DATA_W = 32;

  // Recovery command codes
  typedef enum logic [7:0] {
    CMD_PROT_CAP             = 8'd34,
    CMD_DEVICE_ID            = 8'd35,
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_RECOVERY_STATUS      = 8'd39,
    CMD_HW_STATUS            = 8'd40,
    CMD_INDIRECT_CTRL        = 8'd41,
    CMD_INDIRECT_STATUS      = 8'd42,
    CMD_INDIRECT_DATA        = 8'd43,
    CMD_VENDOR               = 8'd44,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } recovery_cmd_e;

  // One entry per 32-bit recovery register
  typedef enum logic [7:0] {
    CSR_PROT_CAP_0             = 8'd0,
    CSR_PROT_CAP_1             = 8'd1,
    CSR_PROT_CAP_2             = 8'd2,
    CSR_PROT_CAP_3             = 8'd3,
    CSR_DEVICE_ID_0            = 8'd4,
    CSR_DEVICE_ID_1            = 8'd5,
    CSR_DEVICE_ID_2            = 8'd6,
    CSR_DEVICE_ID_3            = 8'd7,
    CSR_DEVICE_ID_4            = 8'd8,
    CSR_DEVICE_ID_5            = 8'd9,
    CSR_DEVICE_ID_6            = 8'd10,
    CSR_DEVICE_STATUS_0        = 8'd11,
    CSR_DEVICE_STATUS_1        = 8'd12,
    CSR_DEVICE_RESET           = 8'd13,
    CSR_RECOVERY_CTRL          = 8'd14,
    CSR_RECOVERY_STATUS        = 8'd15,
    CSR_HW_STATUS              = 8'd16,
    CSR_INDIRECT_FIFO_CTRL_0   = 8'd17,
    CSR_INDIRECT_FIFO_CTRL_1   = 8'd18,
    CSR_INDIRECT_FIFO_STATUS_0 = 8'd19,
    CSR_INDIRECT_FIFO_STATUS_1 = 8'd20,
    CSR_INDIRECT_FIFO_STATUS_2 = 8'd21,
    CSR_INDIRECT_FIFO_STATUS_3 = 8'd22,
    CSR_INDIRECT_FIFO_STATUS_4 = 8'd23,
    CSR_INDIRECT_FIFO_STATUS_5 = 8'd24,
    CSR_INVALID                = 8'd255
  } csr_sel_e;

  // Protocol status byte of device_status
  typedef enum logic [7:0] {
    PROTOCOL_OK        = 8'd0,
    PROTOCOL_READ_ONLY = 8'd1,
    PROTOCOL_PARAMETER = 8'd2,
    PROTOCOL_LENGTH    = 8'd3,
    PROTOCOL_CRC       = 8'd4
  } protocol_error_e;

  typedef enum logic [2:0] {
    IDLE,
    CSR_WRITE,
    CSR_READ,
    DONE,
    ERROR
  } exec_state_e;

  // Decoded command from the receiver
  typedef struct packed {
    logic        is_rd;
    logic [7:0]  cmd;
    logic [15:0] len;
    logic        error;
  } recovery_req_t;

  // Register write bundle, captured by the register block at the edge
  typedef struct packed {
    logic              device_reset_we;
    logic              recovery_ctrl_we;
    logic              fifo_ctrl_0_we;
    logic              fifo_ctrl_1_we;
    logic [DATA_W-1:0] data;
    logic              status_we;
    protocol_error_e   status_protocol;
  } csr_wr_t;

  typedef struct packed {
    logic [DATA_W-1:0] device_reset;
    logic [DATA_W-1:0] recovery_ctrl;
    logic [DATA_W-1:0] fifo_ctrl_0;
    logic [DATA_W-1:0] fifo_ctrl_1;
    logic [DATA_W-1:0] device_status;
  } recovery_csr_t;

endpackage

`default_nettype wire

// ==== design/rx_data_queue.sv ====
// Receive data FIFO feeding payload words to the recovery executor; pop by request/acknowledge
`timescale 1ns/1ps
`default_nettype none

module rx_data_queue #(
  parameter int RX_DEPTH = 8
) (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            push_i,
  input  wire logic [recovery_pkg::DATA_W-1:0] wdata_i,
  input  wire logic                            req_i,
  input  wire logic                            flush_i,
  output logic                                 ack_o,
  output logic      [recovery_pkg::DATA_W-1:0] rdata_o,
  output logic                                 full_o,
  output logic                                 empty_o
);

  localparam int PTR_W = $clog2(RX_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [recovery_pkg::DATA_W-1:0] mem_q [RX_DEPTH];
  logic [PTR_W-1:0]                wr_ptr_q;
  logic [PTR_W-1:0]                rd_ptr_q;
  logic [CNT_W-1:0]                count_q;
  logic                            push_ok;
  logic                            pop_ok;

  assign full_o  = (count_q == CNT_W'(RX_DEPTH));
  assign empty_o = (count_q == '0);

  // Pop is granted in the same cycle as the request
  assign ack_o   = req_i & ~empty_o;
  assign rdata_o = mem_q[rd_ptr_q];

  // Pushes into a full queue are dropped
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = ack_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage, written only when the push is accepted
  always_ff @(posedge clk_i) begin
    if (push_ok && !flush_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/recovery_executor.sv ====
// Executes decoded recovery commands by popping payload words into writable registers and setting status
`timescale 1ns/1ps
`default_nettype none

module recovery_executor (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  cmd_valid_i,
  input  wire recovery_pkg::recovery_req_t           cmd_i,
  input  wire logic                                  rx_ack_i,
  input  wire logic       [recovery_pkg::DATA_W-1:0] rx_rdata_i,
  input  wire recovery_pkg::recovery_csr_t           csr_i,
  output logic                                       cmd_done_o,
  output logic                                       rx_req_o,
  output logic                                       rx_flush_o,
  output recovery_pkg::csr_wr_t                      csr_wr_o
);

  recovery_pkg::exec_state_e     state_q;
  recovery_pkg::exec_state_e     state_d;
  logic [15:0]                   dcnt_q;
  logic [15:0]                   word_cnt;
  recovery_pkg::csr_sel_e        csr_sel_q;
  recovery_pkg::csr_sel_e        start_sel;
  recovery_pkg::protocol_error_e status_q;
  logic                          cmd_take;

  assign cmd_take = (state_q == recovery_pkg::IDLE) && cmd_valid_i;

  // Byte length rounded up to whole words
  assign word_cnt = {2'b00, cmd_i.len[15:2]} + {15'd0, |cmd_i.len[1:0]};

  // First register touched by each command
  always_comb begin
    case (cmd_i.cmd)
      recovery_pkg::CMD_PROT_CAP:
        start_sel = recovery_pkg::CSR_PROT_CAP_0;
      recovery_pkg::CMD_DEVICE_ID:
        start_sel = recovery_pkg::CSR_DEVICE_ID_0;
      recovery_pkg::CMD_DEVICE_STATUS:
        start_sel = recovery_pkg::CSR_DEVICE_STATUS_0;
      recovery_pkg::CMD_DEVICE_RESET:
        start_sel = recovery_pkg::CSR_DEVICE_RESET;
      recovery_pkg::CMD_RECOVERY_CTRL:
        start_sel = recovery_pkg::CSR_RECOVERY_CTRL;
      recovery_pkg::CMD_RECOVERY_STATUS:
        start_sel = recovery_pkg::CSR_RECOVERY_STATUS;
      recovery_pkg::CMD_HW_STATUS:
        start_sel = recovery_pkg::CSR_HW_STATUS;
      recovery_pkg::CMD_INDIRECT_FIFO_CTRL:
        start_sel = recovery_pkg::CSR_INDIRECT_FIFO_CTRL_0;
      recovery_pkg::CMD_INDIRECT_FIFO_STATUS:
        start_sel = recovery_pkg::CSR_INDIRECT_FIFO_STATUS_0;
      default:
        start_sel = recovery_pkg::CSR_INVALID;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= recovery_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      recovery_pkg::IDLE: begin
        if (cmd_valid_i) begin
          if (cmd_i.error) begin
            state_d = recovery_pkg::ERROR;
          end else if (cmd_i.is_rd) begin
            state_d = recovery_pkg::CSR_READ;
          end else begin
            state_d = recovery_pkg::CSR_WRITE;
          end
        end
      end
      // Zero-length writes fall straight through
      recovery_pkg::CSR_WRITE: begin
        if (dcnt_q == 16'd0 || (rx_ack_i && dcnt_q == 16'd1)) begin
          state_d = recovery_pkg::DONE;
        end
      end
      recovery_pkg::CSR_READ: state_d = recovery_pkg::DONE;
      recovery_pkg::ERROR:    state_d = recovery_pkg::DONE;
      recovery_pkg::DONE:     state_d = recovery_pkg::IDLE;
      default:                state_d = recovery_pkg::IDLE;
    endcase
  end

  // Remaining words of the current write
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      dcnt_q <= '0;
    end else if (cmd_take) begin
      dcnt_q <= word_cnt;
    end else if (rx_ack_i) begin
      dcnt_q <= dcnt_q - 16'd1;
    end
  end

  // Selector walks up one register per popped word and sticks at invalid
  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      csr_sel_q <= start_sel;
    end else if (rx_ack_i && csr_sel_q != recovery_pkg::CSR_INVALID) begin
      csr_sel_q <= recovery_pkg::csr_sel_e'(csr_sel_q + 8'd1);
    end
  end

  // Protocol result is known as soon as the command arrives
  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      status_q <= cmd_i.error ? recovery_pkg::PROTOCOL_CRC : recovery_pkg::PROTOCOL_OK;
    end
  end

  assign rx_req_o   = (state_q == recovery_pkg::CSR_WRITE) && (dcnt_q != 16'd0);
  assign rx_flush_o = (state_q == recovery_pkg::ERROR);
  assign cmd_done_o = (state_q == recovery_pkg::DONE);

  // Only writable registers get an enable; other words are dropped
  always_comb begin
    csr_wr_o.device_reset_we  = rx_ack_i && (csr_sel_q == recovery_pkg::CSR_DEVICE_RESET);
    csr_wr_o.recovery_ctrl_we = rx_ack_i && (csr_sel_q == recovery_pkg::CSR_RECOVERY_CTRL);
    csr_wr_o.fifo_ctrl_0_we   = rx_ack_i &&
                                (csr_sel_q == recovery_pkg::CSR_INDIRECT_FIFO_CTRL_0);
    csr_wr_o.fifo_ctrl_1_we   = rx_ack_i &&
                                (csr_sel_q == recovery_pkg::CSR_INDIRECT_FIFO_CTRL_1);
    csr_wr_o.data             = rx_rdata_i;
    // Status write skipped when the byte already holds the result
    csr_wr_o.status_we        = (state_q == recovery_pkg::DONE) &&
                                (csr_i.device_status[15:8] != status_q);
    csr_wr_o.status_protocol  = status_q;
  end

endmodule

`default_nettype wire

// ==== design/recovery_csr_regs.sv ====
// Writable recovery registers and device status, loaded from the executor's write bundle
`timescale 1ns/1ps
`default_nettype none

module recovery_csr_regs (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire recovery_pkg::csr_wr_t csr_wr_i,
  output recovery_pkg::recovery_csr_t csr_o
);

  logic [recovery_pkg::DATA_W-1:0] device_reset_q;
  logic [recovery_pkg::DATA_W-1:0] recovery_ctrl_q;
  logic [recovery_pkg::DATA_W-1:0] fifo_ctrl_0_q;
  logic [recovery_pkg::DATA_W-1:0] fifo_ctrl_1_q;
  logic [recovery_pkg::DATA_W-1:0] device_status_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      device_reset_q <= '0;
    end else if (csr_wr_i.device_reset_we) begin
      device_reset_q <= csr_wr_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      recovery_ctrl_q <= '0;
    end else if (csr_wr_i.recovery_ctrl_we) begin
      recovery_ctrl_q <= csr_wr_i.data;
    end
  end

  // Indirect FIFO control pair
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      fifo_ctrl_0_q <= '0;
    end else if (csr_wr_i.fifo_ctrl_0_we) begin
      fifo_ctrl_0_q <= csr_wr_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      fifo_ctrl_1_q <= '0;
    end else if (csr_wr_i.fifo_ctrl_1_we) begin
      fifo_ctrl_1_q <= csr_wr_i.data;
    end
  end

  // Only the protocol byte of device status is written here
  // device byte [7:0] and reason [31:16] keep their value
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      device_status_q <= '0;
    end else if (csr_wr_i.status_we) begin
      device_status_q[15:8] <= csr_wr_i.status_protocol;
    end
  end

  always_comb begin
    csr_o.device_reset  = device_reset_q;
    csr_o.recovery_ctrl = recovery_ctrl_q;
    csr_o.fifo_ctrl_0   = fifo_ctrl_0_q;
    csr_o.fifo_ctrl_1   = fifo_ctrl_1_q;
    csr_o.device_status = device_status_q;
  end

endmodule

`default_nettype wire

// ==== design/recovery_top.sv ====
// Recovery command subsystem top with receive queue, command executor and register block
`timescale 1ns/1ps
`default_nettype none

module recovery_top #(
  parameter int RX_DEPTH = 8
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic                                  cmd_valid_i,
  input  wire recovery_pkg::recovery_req_t           cmd_i,
  output logic                                       cmd_done_o,
  input  wire logic                                  rx_push_i,
  input  wire logic       [recovery_pkg::DATA_W-1:0] rx_data_i,
  output logic                                       rx_full_o,
  output logic                                       rx_empty_o,
  output recovery_pkg::recovery_csr_t                csr_o
);

  logic                            rx_req;
  logic                            rx_ack;
  logic                            rx_flush;
  logic [recovery_pkg::DATA_W-1:0] rx_rdata;
  recovery_pkg::csr_wr_t           csr_wr;
  recovery_pkg::recovery_csr_t     csr_q;

  rx_data_queue #(
    .RX_DEPTH (RX_DEPTH)
  ) u_rx_data_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rx_push_i),
    .wdata_i (rx_data_i),
    .req_i   (rx_req),
    .flush_i (rx_flush),
    .ack_o   (rx_ack),
    .rdata_o (rx_rdata),
    .full_o  (rx_full_o),
    .empty_o (rx_empty_o)
  );

  recovery_executor u_recovery_executor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .rx_ack_i    (rx_ack),
    .rx_rdata_i  (rx_rdata),
    .csr_i       (csr_q),
    .cmd_done_o  (cmd_done_o),
    .rx_req_o    (rx_req),
    .rx_flush_o  (rx_flush),
    .csr_wr_o    (csr_wr)
  );

  recovery_csr_regs u_recovery_csr_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .csr_wr_i (csr_wr),
    .csr_o    (csr_q)
  );

  assign csr_o = csr_q;

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset source with a 20 ns clock and synchronous reset held low for two edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no <= 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/recovery_asserts.sv ====
// Concurrent checks on executor handshakes, bound into recovery_executor by the testbench
`timescale 1ns/1ps
`default_nettype none

module recovery_asserts (
  input wire logic                        clk_i,
  input wire logic                        rst_ni,
  input wire recovery_pkg::exec_state_e   state_i,
  input wire logic                        cmd_valid_i,
  input wire recovery_pkg::recovery_req_t cmd_i,
  input wire logic                        rx_req_i,
  input wire logic                        rx_ack_i,
  input wire logic                        rx_flush_i,
  input wire logic                        cmd_done_i
);

  // Request is only withdrawn after the queue acknowledged a word
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(rx_req_i) |-> $past(rx_ack_i))
    else $error("rx_req dropped without an acknowledge");

  // Reads and errored commands give one done cycle, two cycles after the strobe
  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == recovery_pkg::IDLE && cmd_valid_i && (cmd_i.is_rd || cmd_i.error))
    |=> !cmd_done_i ##1 cmd_done_i ##1 !cmd_done_i)
    else $error("cmd_done not a single pulse two cycles after the command");

  // Flush only follows an errored command
  flush_in_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_flush_i |-> $past(cmd_valid_i && cmd_i.error))
    else $error("rx_flush without an errored command");

endmodule

`default_nettype wire

// ==== tb/recovery_tb.sv ====
// Self-checking testbench for recovery_top that pushes LFSR words, runs commands and compares registers
`timescale 1ns/1ps
`default_nettype none

module recovery_tb;

  localparam int TIMEOUT  = 100;
  localparam int RX_DEPTH = 8;

  logic                            clk;
  logic                            rst_n;
  logic                            cmd_valid;
  recovery_pkg::recovery_req_t     cmd;
  logic                            cmd_done;
  logic                            rx_push;
  logic [recovery_pkg::DATA_W-1:0] rx_data;
  logic                            rx_full;
  logic                            rx_empty;
  recovery_pkg::recovery_csr_t     csr;

  recovery_pkg::recovery_csr_t     exp_csr;
  logic [recovery_pkg::DATA_W-1:0] exp_words[$];
  logic [31:0]                     lfsr_q;
  int                              latency;

  tb_clk_gen u_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  recovery_top #(
    .RX_DEPTH (RX_DEPTH)
  ) u_recovery_top (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_done_o  (cmd_done),
    .rx_push_i   (rx_push),
    .rx_data_i   (rx_data),
    .rx_full_o   (rx_full),
    .rx_empty_o  (rx_empty),
    .csr_o       (csr)
  );

  bind recovery_executor recovery_asserts u_recovery_asserts (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .state_i     (state_q),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .rx_req_i    (rx_req_o),
    .rx_ack_i    (rx_ack_i),
    .rx_flush_i  (rx_flush_o),
    .cmd_done_i  (cmd_done_o)
  );

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One payload word with one LFSR step per bit
  task automatic next_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // First register index of each command in the register map
  function automatic int start_index(input logic [7:0] code);
    case (code)
      8'd34:   return 0;
      8'd35:   return 4;
      8'd36:   return 11;
      8'd37:   return 13;
      8'd38:   return 14;
      8'd39:   return 15;
      8'd40:   return 16;
      8'd45:   return 17;
      8'd46:   return 19;
      default: return 255;
    endcase
  endfunction

  // Expected registers after one command, consuming the modelled queue
  function automatic recovery_pkg::recovery_csr_t predict(
    input recovery_pkg::recovery_req_t req,
    input recovery_pkg::recovery_csr_t cur
  );
    recovery_pkg::recovery_csr_t nxt;
    int                          idx;
    logic [31:0]                 w;
    nxt = cur;
    if (req.error) begin
      exp_words.delete();
      nxt.device_status[15:8] = 8'd4;
    end else begin
      if (!req.is_rd) begin
        for (int k = 0; k < (int'(req.len) + 3) / 4; k++) begin
          w = exp_words.pop_front();
          idx = start_index(req.cmd);
          if (idx != 255) begin
            idx = idx + k;
          end
          case (idx)
            13:      nxt.device_reset = w;
            14:      nxt.recovery_ctrl = w;
            17:      nxt.fifo_ctrl_0 = w;
            18:      nxt.fifo_ctrl_1 = w;
            default: ;
          endcase
        end
      end
      nxt.device_status[15:8] = 8'd0;
    end
    return nxt;
  endfunction

  task automatic stop_on_error();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_csr(input string name, input recovery_pkg::recovery_csr_t exp_v,
                           input recovery_pkg::recovery_csr_t act_v);
    if (act_v !== exp_v) begin
      $display("FAILED %s: expected %h actual %h", name, exp_v, act_v);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("FAILED %s: expected %b actual %b", name, exp_v, act_v);
      stop_on_error();
    end
  endtask

  task automatic check_latency(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
      $display("FAILED %s: expected %0d actual %0d", name, exp_v, act_v);
      stop_on_error();
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!rst_n) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("Reset was never released");
        stop_on_error();
      end
    end
  endtask

  task automatic push_words(input int count);
    logic [31:0] w;
    for (int i = 0; i < count; i++) begin
      next_word(w);
      @(posedge clk);
      rx_push <= 1'b1;
      rx_data <= w;
      // A full queue drops the word
      if (exp_words.size() < RX_DEPTH) begin
        exp_words.push_back(w);
      end
    end
    @(posedge clk);
    rx_push <= 1'b0;
    @(negedge clk);
    check_bit("push full", exp_words.size() == RX_DEPTH, rx_full);
  endtask

  // Strobe one command, wait for done, then compare registers and queue state
  task automatic run_cmd(input string name, input logic is_rd, input logic [7:0] code,
                         input logic [15:0] len, input logic err);
    recovery_pkg::recovery_req_t req;
    req.is_rd = is_rd;
    req.cmd   = code;
    req.len   = len;
    req.error = err;
    exp_csr = predict(req, exp_csr);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= req;
    latency = 0;
    do begin
      @(posedge clk);
      cmd_valid <= 1'b0;
      latency++;
      @(negedge clk);
      if (!cmd_done && latency > TIMEOUT) begin
        $display("Command %s timed out waiting for cmd_done", name);
        stop_on_error();
      end
    end while (!cmd_done);
    // Status byte lands at the edge after done
    @(posedge clk);
    @(negedge clk);
    check_csr(name, exp_csr, csr);
    check_bit({name, " empty"}, exp_words.size() == 0, rx_empty);
  endtask

  initial begin
    cmd_valid <= 1'b0;
    cmd       <= '0;
    rx_push   <= 1'b0;
    rx_data   <= '0;
    exp_csr = '0;
    lfsr_q  = 32'd3;
    latency = 0;
    wait_reset();
    @(negedge clk);
    check_csr("reset", exp_csr, csr);
    check_bit("reset empty", 1'b1, rx_empty);
    check_bit("reset full", 1'b0, rx_full);

    push_words(1);
    run_cmd("single_word", 1'b0, recovery_pkg::CMD_RECOVERY_CTRL, 16'd4, 1'b0);
    push_words(2);
    run_cmd("two_words", 1'b0, recovery_pkg::CMD_INDIRECT_FIFO_CTRL, 16'd8, 1'b0);
    // 5 bytes round up to 2 words and the second one reaches recovery_ctrl
    push_words(2);
    run_cmd("rounding", 1'b0, recovery_pkg::CMD_DEVICE_RESET, 16'd5, 1'b0);
    push_words(2);
    run_cmd("read_only", 1'b0, recovery_pkg::CMD_PROT_CAP, 16'd8, 1'b0);
    push_words(3);
    run_cmd("error", 1'b0, recovery_pkg::CMD_RECOVERY_CTRL, 16'd8, 1'b1);
    check_latency("error latency", 2, latency);
    push_words(2);
    run_cmd("read", 1'b1, recovery_pkg::CMD_DEVICE_STATUS, 16'd4, 1'b0);
    check_latency("read latency", 2, latency);
    // Words left behind by the read
    run_cmd("drain", 1'b0, recovery_pkg::CMD_RECOVERY_CTRL, 16'd8, 1'b0);
    // One word more than the queue holds is dropped
    push_words(RX_DEPTH + 1);
    run_cmd("full_drain", 1'b0, recovery_pkg::CMD_RECOVERY_CTRL, 16'd32, 1'b0);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
design/recovery_pkg.sv
design/rx_data_queue.sv
design/recovery_executor.sv
design/recovery_csr_regs.sv
design/recovery_top.sv
tb/tb_clk_gen.sv
tb/recovery_asserts.sv
tb/recovery_tb.sv

// ==== Makefile ====
TOP := recovery_tb

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
